// File: arbiter/cu_arbiter_control.sv
/*
 * Central control for the rank units
 * Job dispatch, read and write arbitration, response routing, done counters
 */

`timescale 1ns/10ps

module cu_arbiter_control #(
	parameter int NUM_VERTEX_CU = 4
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         enabled,
	input  logic                         job_valid,
	input  graph_cu_pkg::vertex_job_t    job,
	output logic                         job_request,
	input  logic [NUM_VERTEX_CU-1:0]     idle,
	input  logic [NUM_VERTEX_CU-1:0]     read_request,
	input  graph_cu_pkg::read_command_t  read_command [NUM_VERTEX_CU],
	input  logic [NUM_VERTEX_CU-1:0]     write_request,
	input  graph_cu_pkg::rank_write_t    rank_write [NUM_VERTEX_CU],
	output logic [NUM_VERTEX_CU-1:0]     read_grant,
	output logic [NUM_VERTEX_CU-1:0]     write_grant,
	output logic [NUM_VERTEX_CU-1:0]     job_strobe,
	output logic [NUM_VERTEX_CU-1:0]     response_strobe,
	output graph_cu_pkg::vertex_job_t    job_out,
	output graph_cu_pkg::rank_t          response_data,
	input  logic                         response_valid,
	input  graph_cu_pkg::read_response_t response,
	output logic                         read_valid,
	output graph_cu_pkg::read_command_t  read_command_out,
	output logic                         write_valid,
	output graph_cu_pkg::rank_write_t    write_out,
	output graph_cu_pkg::vertex_total_t  vertex_done_count,
	output graph_cu_pkg::edge_total_t    edge_done_count
);

	logic                        job_outstanding;
	logic                        job_request_next;
	logic [NUM_VERTEX_CU-1:0]    unit_free;
	logic [NUM_VERTEX_CU-1:0]    dispatch_onehot;
	graph_cu_pkg::read_command_t read_select;
	graph_cu_pkg::rank_write_t   write_select;

	////////////////////////////////////////////////////////////////////////////
	// Job request and dispatch
	////////////////////////////////////////////////////////////////////////////

	// A unit with a dispatch in flight still shows idle for one cycle
	assign unit_free        = idle & ~job_strobe;
	assign dispatch_onehot  = unit_free & (~unit_free + 1'b1);
	assign job_request_next = enabled & ~job_outstanding & (unit_free != '0);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_request     <= 1'b0;
			job_outstanding <= 1'b0;
			job_strobe      <= '0;
		end else begin
			job_request <= job_request_next;
			if (job_request_next) begin
				job_outstanding <= 1'b1;
			end else if (job_valid) begin
				job_outstanding <= 1'b0;
			end
			job_strobe <= job_valid ? dispatch_onehot : '0;
		end
	end

	always_ff @(posedge clock) begin
		job_out <= job;
	end

	assert property (@(posedge clock) disable iff (!rstn)
		job_valid |-> job_outstanding)
		else $error("job arrived without an outstanding request");

	////////////////////////////////////////////////////////////////////////////
	// Read and write arbitration
	////////////////////////////////////////////////////////////////////////////

	rr_arbiter #(
		.WIDTH(NUM_VERTEX_CU)
	) read_arbiter_inst (
		.clock  (clock       ),
		.rstn   (rstn        ),
		.request(read_request),
		.grant  (read_grant  )
	);

	rr_arbiter #(
		.WIDTH(NUM_VERTEX_CU)
	) write_arbiter_inst (
		.clock  (clock        ),
		.rstn   (rstn         ),
		.request(write_request),
		.grant  (write_grant  )
	);

	// Grant vectors are one-hot, so a masked OR picks the winner
	always_comb begin
		read_select  = '0;
		write_select = '0;
		for (int i = 0; i < NUM_VERTEX_CU; i++) begin
			if (read_grant[i]) begin
				read_select = read_command[i];
			end
			if (write_grant[i]) begin
				write_select = rank_write[i];
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_valid  <= 1'b0;
			write_valid <= 1'b0;
		end else begin
			read_valid  <= (read_grant != '0);
			write_valid <= (write_grant != '0);
		end
	end

	always_ff @(posedge clock) begin
		read_command_out <= read_select;
		write_out        <= write_select;
	end

	////////////////////////////////////////////////////////////////////////////
	// Response routing by tag
	////////////////////////////////////////////////////////////////////////////

	genvar i;
	generate
		for (i = 0; i < NUM_VERTEX_CU; i++) begin : gen_response_route
			assign response_strobe[i] = response_valid &&
				(response.tag == graph_cu_pkg::cu_tag_t'(i));
		end
	endgenerate

	assign response_data = response.data;

	// Done counters follow the forwarded writes
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_done_count <= '0;
			edge_done_count   <= '0;
		end else if (write_valid) begin
			vertex_done_count <= vertex_done_count + 1'b1;
			edge_done_count   <= edge_done_count + graph_cu_pkg::edge_total_t'(write_out.edge_count);
		end
	end

endmodule

// File: arbiter/rr_arbiter.sv
/*
 * Round-robin arbiter with a one-hot grant
 */

`timescale 1ns/10ps

module rr_arbiter #(
	parameter int WIDTH = 4
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic [WIDTH-1:0] request,
	output logic [WIDTH-1:0] grant
);

	// Lines strictly above the last winner get first pick
	logic [WIDTH-1:0] priority_mask;
	logic [WIDTH-1:0] masked_request;
	logic [WIDTH-1:0] masked_grant;
	logic [WIDTH-1:0] plain_grant;
	logic [WIDTH-1:0] grant_shift;

	assign masked_request = request & priority_mask;
	assign masked_grant   = masked_request & (~masked_request + 1'b1);
	assign plain_grant    = request & (~request + 1'b1);
	assign grant          = (masked_request != '0) ? masked_grant : plain_grant;
	assign grant_shift    = grant << 1;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			priority_mask <= '1;
		end else if (grant != '0) begin
			priority_mask <= ~(grant_shift - 1'b1);
		end
	end

	assert property (@(posedge clock) disable iff (!rstn)
		$onehot0(grant) && ((grant & ~request) == '0))
		else $error("arbiter grant not one-hot or not requested");

endmodule

// File: common/graph_cu_pkg.sv
/*
 * Shared widths, job and memory structs and the rank-unit state enum
 * for the graph compute cluster control block
 */

package graph_cu_pkg;

	// Upper bound on rank units, sets the tag width
	localparam int MAX_VERTEX_CU = 8;
	localparam int CU_TAG_BITS   = $clog2(MAX_VERTEX_CU);

	////////////////////////////////////////////////////////////////////////////
	// Scalar widths
	////////////////////////////////////////////////////////////////////////////

	typedef logic [15:0]            vertex_id_t;
	typedef logic [15:0]            edge_addr_t;
	typedef logic [7:0]             edge_count_t;
	typedef logic [31:0]            rank_t;
	typedef logic [CU_TAG_BITS-1:0] cu_tag_t;
	typedef logic [15:0]            vertex_total_t;
	typedef logic [23:0]            edge_total_t;

	////////////////////////////////////////////////////////////////////////////
	// Bundles
	////////////////////////////////////////////////////////////////////////////

	// One vertex job as handed out by the outside
	typedef struct packed {
		vertex_id_t  vertex_id;
		edge_addr_t  edge_base;
		edge_count_t edge_count;
	} vertex_job_t;

	// Tag names the unit that gets the response back
	typedef struct packed {
		cu_tag_t    tag;
		edge_addr_t address;
	} read_command_t;

	typedef struct packed {
		cu_tag_t tag;
		rank_t   data;
	} read_response_t;

	typedef struct packed {
		vertex_id_t  vertex_id;
		edge_count_t edge_count;
		rank_t       rank_sum;
	} rank_write_t;

	// Rank unit FSM
	typedef enum logic [1:0] {
		CU_IDLE,
		CU_ISSUE,
		CU_COLLECT,
		CU_RESULT
	} cu_state_t;

endpackage

// File: compute_unit/vertex_rank_unit.sv
/*
 * Vertex rank unit
 * Issues one read per edge and sums the returned words into one result write
 */

`timescale 1ns/10ps

module vertex_rank_unit #(
	parameter graph_cu_pkg::cu_tag_t CU_TAG = '0
) (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        job_valid,
	input  graph_cu_pkg::vertex_job_t   job,
	output logic                        idle,
	output logic                        read_request,
	input  logic                        read_grant,
	output graph_cu_pkg::read_command_t read_command,
	input  logic                        response_valid,
	input  graph_cu_pkg::rank_t         response_data,
	output logic                        write_request,
	input  logic                        write_grant,
	output graph_cu_pkg::rank_write_t   rank_write
);

	graph_cu_pkg::cu_state_t   state;
	graph_cu_pkg::edge_count_t reads_left;
	graph_cu_pkg::edge_count_t responses_left;

	// Job payload, loaded on the job strobe
	graph_cu_pkg::vertex_id_t  vertex_id;
	graph_cu_pkg::edge_count_t edge_count;
	graph_cu_pkg::edge_addr_t  next_address;
	graph_cu_pkg::rank_t       rank_sum;

	////////////////////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state          <= graph_cu_pkg::CU_IDLE;
			reads_left     <= '0;
			responses_left <= '0;
		end else begin
			case (state)
				graph_cu_pkg::CU_IDLE: begin
					if (job_valid) begin
						reads_left     <= job.edge_count;
						responses_left <= job.edge_count;
						// Zero edges means nothing to read
						if (job.edge_count == '0) begin
							state <= graph_cu_pkg::CU_RESULT;
						end else begin
							state <= graph_cu_pkg::CU_ISSUE;
						end
					end
				end
				graph_cu_pkg::CU_ISSUE: begin
					if (read_grant) begin
						reads_left <= reads_left - 1'b1;
						if (reads_left == 8'd1) begin
							state <= graph_cu_pkg::CU_COLLECT;
						end
					end
					if (response_valid) begin
						responses_left <= responses_left - 1'b1;
					end
				end
				graph_cu_pkg::CU_COLLECT: begin
					if (response_valid) begin
						responses_left <= responses_left - 1'b1;
						if (responses_left == 8'd1) begin
							state <= graph_cu_pkg::CU_RESULT;
						end
					end
				end
				graph_cu_pkg::CU_RESULT: begin
					// Done once the write has been taken
					if (write_grant) begin
						state <= graph_cu_pkg::CU_IDLE;
					end
				end
				default: begin
					state <= graph_cu_pkg::CU_IDLE;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Address stepping and accumulation
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (state == graph_cu_pkg::CU_IDLE && job_valid) begin
			vertex_id    <= job.vertex_id;
			edge_count   <= job.edge_count;
			next_address <= job.edge_base;
			rank_sum     <= '0;
		end else begin
			if (read_grant) begin
				next_address <= next_address + 1'b1;
			end
			// Wraps around on overflow
			if (response_valid) begin
				rank_sum <= rank_sum + response_data;
			end
		end
	end

	assign idle          = (state == graph_cu_pkg::CU_IDLE);
	assign read_request  = (state == graph_cu_pkg::CU_ISSUE);
	assign write_request = (state == graph_cu_pkg::CU_RESULT);

	assign read_command.tag     = CU_TAG;
	assign read_command.address = next_address;

	assign rank_write.vertex_id  = vertex_id;
	assign rank_write.edge_count = edge_count;
	assign rank_write.rank_sum   = rank_sum;

	// Responses are routed only to a unit that has reads in flight
	assert property (@(posedge clock) disable iff (!rstn)
		response_valid |-> (state != graph_cu_pkg::CU_IDLE))
		else $error("response routed to idle rank unit %0d", CU_TAG);

endmodule

// File: graph_algorithm_control.f
common/graph_cu_pkg.sv
arbiter/rr_arbiter.sv
arbiter/cu_arbiter_control.sv
compute_unit/vertex_rank_unit.sv
hdl/graph_algorithm_control.sv
sim/edge_memory_model.sv
sim/graph_algorithm_control_tb.sv

// File: hdl/graph_algorithm_control.sv
/*
 * Graph compute cluster top level
 * Enable register, input and output register stages, arbiter and rank units
 */

`timescale 1ns/10ps

module graph_algorithm_control #(
	parameter int NUM_VERTEX_CU = 4
) (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        enabled_in,
	input  logic                        job_valid,
	input  graph_cu_pkg::vertex_job_t   job,
	output logic                        job_request,
	output logic                        read_valid,
	output graph_cu_pkg::read_command_t read_command,
	input  logic                        response_valid,
	input  graph_cu_pkg::read_response_t response,
	output logic                        write_valid,
	output graph_cu_pkg::rank_write_t   rank_write,
	output graph_cu_pkg::vertex_total_t vertex_done_count,
	output graph_cu_pkg::edge_total_t   edge_done_count
);

	logic enabled;

	// Input stage
	logic                         job_valid_q;
	graph_cu_pkg::vertex_job_t    job_q;
	logic                         response_valid_q;
	graph_cu_pkg::read_response_t response_q;

	// Arbiter side of the output stage
	logic                         job_request_d;
	logic                         read_valid_d;
	graph_cu_pkg::read_command_t  read_command_d;
	logic                         write_valid_d;
	graph_cu_pkg::rank_write_t    rank_write_d;
	graph_cu_pkg::vertex_total_t  vertex_done_d;
	graph_cu_pkg::edge_total_t    edge_done_d;

	// Per-unit nets
	logic [NUM_VERTEX_CU-1:0]    cu_idle;
	logic [NUM_VERTEX_CU-1:0]    cu_read_request;
	logic [NUM_VERTEX_CU-1:0]    cu_read_grant;
	logic [NUM_VERTEX_CU-1:0]    cu_write_request;
	logic [NUM_VERTEX_CU-1:0]    cu_write_grant;
	logic [NUM_VERTEX_CU-1:0]    cu_job_strobe;
	logic [NUM_VERTEX_CU-1:0]    cu_response_strobe;
	graph_cu_pkg::read_command_t cu_read_command [NUM_VERTEX_CU];
	graph_cu_pkg::rank_write_t   cu_rank_write [NUM_VERTEX_CU];
	graph_cu_pkg::vertex_job_t   cu_job;
	graph_cu_pkg::rank_t         cu_response_data;

	////////////////////////////////////////////////////////////////////////////
	// Enable and input stage
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled          <= 1'b0;
			job_valid_q      <= 1'b0;
			response_valid_q <= 1'b0;
		end else begin
			enabled          <= enabled_in;
			// Strobes only pass while enabled
			job_valid_q      <= enabled & job_valid;
			response_valid_q <= enabled & response_valid;
		end
	end

	always_ff @(posedge clock) begin
		job_q      <= job;
		response_q <= response;
	end

	////////////////////////////////////////////////////////////////////////////
	// Output stage
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_request       <= 1'b0;
			read_valid        <= 1'b0;
			write_valid       <= 1'b0;
			vertex_done_count <= '0;
			edge_done_count   <= '0;
		end else begin
			job_request       <= job_request_d;
			read_valid        <= read_valid_d;
			write_valid       <= write_valid_d;
			vertex_done_count <= vertex_done_d;
			edge_done_count   <= edge_done_d;
		end
	end

	always_ff @(posedge clock) begin
		read_command <= read_command_d;
		rank_write   <= rank_write_d;
	end

	////////////////////////////////////////////////////////////////////////////
	// Arbiter and rank units
	////////////////////////////////////////////////////////////////////////////

	cu_arbiter_control #(
		.NUM_VERTEX_CU(NUM_VERTEX_CU)
	) cu_arbiter_control_inst (
		.clock            (clock             ),
		.rstn             (rstn              ),
		.enabled          (enabled           ),
		.job_valid        (job_valid_q       ),
		.job              (job_q             ),
		.job_request      (job_request_d     ),
		.idle             (cu_idle           ),
		.read_request     (cu_read_request   ),
		.read_command     (cu_read_command   ),
		.write_request    (cu_write_request  ),
		.rank_write       (cu_rank_write     ),
		.read_grant       (cu_read_grant     ),
		.write_grant      (cu_write_grant    ),
		.job_strobe       (cu_job_strobe     ),
		.response_strobe  (cu_response_strobe),
		.job_out          (cu_job            ),
		.response_data    (cu_response_data  ),
		.response_valid   (response_valid_q  ),
		.response         (response_q        ),
		.read_valid       (read_valid_d      ),
		.read_command_out (read_command_d    ),
		.write_valid      (write_valid_d     ),
		.write_out        (rank_write_d      ),
		.vertex_done_count(vertex_done_d     ),
		.edge_done_count  (edge_done_d       )
	);

	genvar i;
	generate
		for (i = 0; i < NUM_VERTEX_CU; i++) begin : gen_rank_unit
			vertex_rank_unit #(
				.CU_TAG(graph_cu_pkg::cu_tag_t'(i))
			) vertex_rank_unit_inst (
				.clock         (clock                 ),
				.rstn          (rstn                  ),
				.job_valid     (cu_job_strobe[i]      ),
				.job           (cu_job                ),
				.idle          (cu_idle[i]            ),
				.read_request  (cu_read_request[i]    ),
				.read_grant    (cu_read_grant[i]      ),
				.read_command  (cu_read_command[i]    ),
				.response_valid(cu_response_strobe[i] ),
				.response_data (cu_response_data      ),
				.write_request (cu_write_request[i]   ),
				.write_grant   (cu_write_grant[i]     ),
				.rank_write    (cu_rank_write[i]      )
			);
		end
	endgenerate

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the graph compute cluster testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
	--top-module graph_algorithm_control_tb \
	-f graph_algorithm_control.f -o graph_sim \
	&& ./obj_dir/graph_sim | tee /dev/stderr | grep -qF '*** TEST PASSED ***' \
	&& echo "Simulation run succeeded" \
	|| { echo "Simulation run did not succeed"; exit 1; }

// File: sim/edge_memory_model.sv
/*
 * Edge memory model for the testbench
 * Answers each read with its word after 1 to 8 cycles, out of order
 */

`timescale 1ns/10ps

module edge_memory_model #(
	parameter int          MEM_WORDS = 256,
	parameter logic [15:0] LFSR_SEED = 16'd26
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         read_valid,
	input  graph_cu_pkg::read_command_t  read_command,
	input  graph_cu_pkg::rank_t          memory_words [MEM_WORDS],
	output logic                         response_valid,
	output graph_cu_pkg::read_response_t response
);

	graph_cu_pkg::cu_tag_t    pend_tag [$];
	graph_cu_pkg::edge_addr_t pend_addr [$];
	int                       pend_due [$];
	int                       cycle;
	logic [15:0]              lfsr;

	// Galois form, taps 16,14,13,11
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 16'hB400;
		end
		return state >> 1;
	endfunction

	initial begin
		response_valid = 1'b0;
		response       = '0;
		lfsr           = LFSR_SEED;
		cycle          = 0;
	end

	always @(negedge clock) begin : answer_reads
		logic [2:0] delay_bits;
		int         pick;
		pick           = -1;
		cycle          = cycle + 1;
		response_valid = 1'b0;
		if (rstn && read_valid) begin
			// One LFSR step per delay bit
			for (int b = 0; b < 3; b++) begin
				delay_bits[b] = lfsr[0];
				lfsr          = lfsr_step(lfsr);
			end
			pend_tag.push_back(read_command.tag);
			pend_addr.push_back(read_command.address);
			pend_due.push_back(cycle + int'(delay_bits) + 1);
		end
		for (int i = 0; i < pend_due.size(); i++) begin
			if (pick < 0 && pend_due[i] <= cycle) begin
				pick = i;
			end
		end
		// One response per cycle at most
		if (pick >= 0) begin
			response_valid = 1'b1;
			response.tag   = pend_tag[pick];
			response.data  = memory_words[int'(pend_addr[pick]) % MEM_WORDS];
			pend_tag.delete(pick);
			pend_addr.delete(pick);
			pend_due.delete(pick);
		end
	end

endmodule

// File: sim/graph_algorithm_control_tb.sv
/*
 * Testbench for the graph compute cluster control block
 * Clock, reset, job driving, read and write checking, watchdog
 */

`timescale 1ns/10ps

module graph_algorithm_control_tb;

	localparam int NUM_VERTEX_CU = 4;
	localparam int DATA_WORDS    = 512;
	localparam int MEM_WORDS     = 256;
	localparam int JOB_BASE      = 'h100;
	localparam int MAX_JOBS      = 64;

	logic                         clock;
	logic                         rstn;
	logic                         enabled_in;
	logic                         job_valid;
	graph_cu_pkg::vertex_job_t    job;
	logic                         job_request;
	logic                         read_valid;
	graph_cu_pkg::read_command_t  read_command;
	logic                         response_valid;
	graph_cu_pkg::read_response_t response;
	logic                         write_valid;
	graph_cu_pkg::rank_write_t    rank_write;
	graph_cu_pkg::vertex_total_t  vertex_done_count;
	graph_cu_pkg::edge_total_t    edge_done_count;

	// Test data image with memory words at the bottom and the job list from JOB_BASE
	logic [31:0]         data_words [DATA_WORDS];
	graph_cu_pkg::rank_t memory_words [MEM_WORDS];
	int                  read_hits [MEM_WORDS];
	int                  job_tag [MAX_JOBS];
	bit                  job_written [MAX_JOBS];
	int                  job_count;
	int                  total_edges;
	int                  jobs_issued;
	int                  writes_seen;
	bit                  loaded;

	graph_algorithm_control #(
		.NUM_VERTEX_CU(NUM_VERTEX_CU)
	) DUT (
		.clock            (clock            ),
		.rstn             (rstn             ),
		.enabled_in       (enabled_in       ),
		.job_valid        (job_valid        ),
		.job              (job              ),
		.job_request      (job_request      ),
		.read_valid       (read_valid       ),
		.read_command     (read_command     ),
		.response_valid   (response_valid   ),
		.response         (response         ),
		.write_valid      (write_valid      ),
		.rank_write       (rank_write       ),
		.vertex_done_count(vertex_done_count),
		.edge_done_count  (edge_done_count  )
	);

	edge_memory_model #(
		.MEM_WORDS(MEM_WORDS)
	) edge_memory (
		.clock         (clock         ),
		.rstn          (rstn          ),
		.read_valid    (read_valid    ),
		.read_command  (read_command  ),
		.memory_words  (memory_words  ),
		.response_valid(response_valid),
		.response      (response      )
	);

	always #5 clock = ~clock;

	////////////////////////////////////////////////////////////////////////////
	// Job list access and failure reporting
	////////////////////////////////////////////////////////////////////////////

	// Each job takes three words of {vertex id, edge base}, edge count and expected sum
	function automatic graph_cu_pkg::vertex_job_t job_entry(input int k);
		graph_cu_pkg::vertex_job_t entry;
		entry.vertex_id  = data_words[JOB_BASE + 1 + 3 * k][31:16];
		entry.edge_base  = data_words[JOB_BASE + 1 + 3 * k][15:0];
		entry.edge_count = data_words[JOB_BASE + 2 + 3 * k][7:0];
		return entry;
	endfunction

	function automatic graph_cu_pkg::rank_t job_sum(input int k);
		return data_words[JOB_BASE + 3 + 3 * k];
	endfunction

	task automatic end_run_failed();
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic value_error(input string msg);
		$display("[ERROR] %0t: %s", $time, msg);
		end_run_failed();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Read and write checking
	////////////////////////////////////////////////////////////////////////////

	task automatic check_read(input graph_cu_pkg::read_command_t cmd);
		graph_cu_pkg::vertex_job_t entry;
		int owners;
		int owner;
		int address;
		owners  = 0;
		owner   = -1;
		address = int'(cmd.address);
		assert (address < MEM_WORDS) else value_error($sformatf(
			"read address %04h outside test memory", cmd.address));
		for (int k = 0; k < jobs_issued; k++) begin
			entry = job_entry(k);
			if (address >= int'(entry.edge_base) &&
				address < int'(entry.edge_base) + int'(entry.edge_count)) begin
				owners++;
				owner = k;
			end
		end
		assert (owners == 1) else value_error($sformatf(
			"read address %04h lies in %0d issued jobs", cmd.address, owners));
		assert (int'(cmd.tag) < NUM_VERTEX_CU) else value_error($sformatf(
			"read address %04h carries tag %0d with no rank unit",
			cmd.address, cmd.tag));
		// All reads of one job come from the same rank unit
		if (job_tag[owner] < 0) begin
			job_tag[owner] = int'(cmd.tag);
		end
		assert (job_tag[owner] == int'(cmd.tag)) else value_error($sformatf(
			"read address %04h tag %0d, earlier reads of its job used tag %0d",
			cmd.address, cmd.tag, job_tag[owner]));
		assert (read_hits[address] == 0) else value_error($sformatf(
			"read address %04h issued twice", cmd.address));
		read_hits[address]++;
	endtask

	task automatic check_write(input graph_cu_pkg::rank_write_t wr);
		graph_cu_pkg::vertex_job_t entry;
		int match;
		match = -1;
		for (int k = 0; k < jobs_issued; k++) begin
			entry = job_entry(k);
			if (entry.vertex_id == wr.vertex_id) begin
				match = k;
			end
		end
		assert (match >= 0) else value_error($sformatf(
			"write for vertex %04h that was never issued", wr.vertex_id));
		entry = job_entry(match);
		assert (!job_written[match]) else value_error($sformatf(
			"second write for vertex %04h", wr.vertex_id));
		assert (wr.edge_count == entry.edge_count) else value_error($sformatf(
			"vertex %04h edge count %0d, expected %0d",
			wr.vertex_id, wr.edge_count, entry.edge_count));
		assert (wr.rank_sum == job_sum(match)) else value_error($sformatf(
			"vertex %04h rank sum %08h, expected %08h",
			wr.vertex_id, wr.rank_sum, job_sum(match)));
		job_written[match] = 1'b1;
		writes_seen++;
	endtask

	// Registered outputs are stable at the falling edge
	always @(negedge clock) begin
		if (rstn) begin
			if (read_valid) begin
				check_read(read_command);
			end
			if (write_valid) begin
				check_write(rank_write);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin : main_sequence
		graph_cu_pkg::vertex_job_t entry;
		clock       = 1'b0;
		rstn        = 1'b0;
		enabled_in  = 1'b0;
		job_valid   = 1'b0;
		job         = '0;
		jobs_issued = 0;
		writes_seen = 0;
		total_edges = 0;
		loaded      = 1'b0;
		foreach (data_words[i]) begin
			data_words[i] = 32'h5A00_0000 | 32'(i);
		end
		foreach (read_hits[i]) begin
			read_hits[i] = 0;
		end
		foreach (job_tag[i]) begin
			job_tag[i] = -1;
		end
		foreach (job_written[i]) begin
			job_written[i] = 1'b0;
		end
		$readmemh("sim/graph_testdata.txt", data_words);
		job_count = int'(data_words[JOB_BASE]);
		assert (job_count >= 1 && job_count <= MAX_JOBS) else begin
			$display("Test data file holds no usable job count");
			end_run_failed();
		end
		for (int k = 0; k < job_count; k++) begin
			entry = job_entry(k);
			total_edges += int'(entry.edge_count);
		end
		for (int a = 0; a < MEM_WORDS; a++) begin
			memory_words[a] = data_words[a];
		end
		loaded = 1'b1;

		repeat (3) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;

		// Quiet while disabled
		repeat (12) begin
			@(negedge clock);
			assert (!job_request && !read_valid && !write_valid &&
				vertex_done_count == '0 && edge_done_count == '0)
				else value_error($sformatf(
					"activity while disabled, request %b read %b write %b",
					job_request, read_valid, write_valid));
		end
		enabled_in = 1'b1;

		// Answer each request in list order after 0 to 2 cycles
		for (int k = 0; k < job_count; k++) begin
			entry = job_entry(k);
			do @(negedge clock); while (!job_request);
			repeat (k % 3) @(negedge clock);
			job_valid = 1'b1;
			job       = entry;
			jobs_issued++;
			@(negedge clock);
			job_valid = 1'b0;
		end

		while (writes_seen < job_count) @(negedge clock);
		// Counters trail the write strobe through the pipeline
		repeat (4) @(negedge clock);

		for (int k = 0; k < job_count; k++) begin
			entry = job_entry(k);
			for (int a = int'(entry.edge_base);
				a < int'(entry.edge_base) + int'(entry.edge_count); a++) begin
				assert (read_hits[a] == 1) else value_error($sformatf(
					"address %04h read %0d times", a, read_hits[a]));
			end
		end
		assert (vertex_done_count == 16'(job_count)) else value_error($sformatf(
			"vertex_done_count %0d, expected %0d", vertex_done_count, job_count));
		assert (edge_done_count == 24'(total_edges)) else value_error($sformatf(
			"edge_done_count %0d, expected %0d", edge_done_count, total_edges));

		$display("*** TEST PASSED ***");
		$finish;
	end

	initial begin : watchdog
		int limit;
		wait (loaded);
		limit = job_count * 64 + total_edges * 16;
		repeat (limit) @(posedge clock);
		$display("Timeout: the results did not all arrive within %0d cycles", limit);
		end_run_failed();
	end

endmodule

// File: sim/graph_testdata.txt
// Words 000..02F hold the edge memory, eight words per line
// At 100 the job count, then one job per line:
//   {vertex_id, edge_base}  edge_count  expected rank sum
@000
00000001 00000002 00000003 00000004 00000005 00000006 00000007 00000008
10000000 20000000 30000000 40000000 50000000 60000000 70000000 80000000
FFFFFFFF FFFFFFFE 00000003 00000010 12345678 9ABCDEF0 0F0F0F0F F0F0F0F0
00000100 00000200 00000300 00000400 00000500 00000600 00000700 00000800
80000000 80000000 80000001 00000011 00000022 00000033 00000044 00000055
DEADBEEF 00000001 CAFEF00D 11111111 22222222 33333333 44444444 55555555
@100
0000000A
// small words
00010000 00000008 00000024
// sum wraps past 2^32
00020008 00000008 40000000
00030010 00000004 00000010
00100014 00000004 ACF13567
// zero edges
00200018 00000000 00000000
00210018 00000008 00002400
00300020 00000003 80000001
00310023 00000005 000000FF
// single edge
00400028 00000001 DEADBEEF
00410029 00000007 CAFEF00D
